/* verilog/rv_pkg.sv */
package rv_pkg;

    // Machine word width
    parameter int XLEN = 32;

    // Words, addresses and instructions share one type
    typedef logic [XLEN-1:0] word_t;

    // Register index, 32 architectural registers
    typedef logic [4:0] reg_addr_t;

    // ALU operations of the kept RV32I subset
    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_SLT  = 4'd5,
        ALU_SLTU = 4'd6,
        ALU_SLL  = 4'd7,
        ALU_SRL  = 4'd8,
        ALU_SRA  = 4'd9
    } alu_op_e;

    // Operand source in EX
    typedef enum logic [1:0] {
        FWD_NONE = 2'd0,
        FWD_MEM  = 2'd1,
        FWD_WB   = 2'd2
    } fwd_sel_e;

    // Major opcodes still decoded
    parameter logic [6:0] OPC_OP     = 7'b0110011;
    parameter logic [6:0] OPC_OP_IMM = 7'b0010011;
    parameter logic [6:0] OPC_LOAD   = 7'b0000011;
    parameter logic [6:0] OPC_STORE  = 7'b0100011;

endpackage

/* verilog/fetch_stage.sv */
`timescale 1ns/1ns

module fetch_stage #(
    parameter rv_pkg::word_t RESET_PC = 32'h0000_0000
) (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          stall,
    output rv_pkg::word_t imem_addr,
    input  rv_pkg::word_t imem_data,
    output rv_pkg::word_t instr_id
);
    import rv_pkg::*;

    // addi x0, x0, 0
    localparam word_t NOP = 32'h0000_0013;

    word_t pc;

    // Memory answers in the same cycle, so the PC is the fetch address
    assign imem_addr = pc;

    // PC and IF/ID both freeze for a load-use stall
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc       <= RESET_PC;
            instr_id <= NOP;
        end else if (!stall) begin
            pc       <= pc + 32'd4;
            instr_id <= imem_data;
        end
    end

endmodule

/* verilog/decode_stage.sv */
`timescale 1ns/1ns

module decode_stage (
    input  rv_pkg::word_t     instr_id,
    output rv_pkg::reg_addr_t rs1_addr,
    output rv_pkg::reg_addr_t rs2_addr,
    input  rv_pkg::word_t     rs1_data,
    input  rv_pkg::word_t     rs2_data,
    output rv_pkg::word_t     op_a_id,
    output rv_pkg::word_t     op_b_id,
    input  rv_pkg::reg_addr_t rd_ex,
    input  logic              mem_read_ex,
    output logic              stall,
    output rv_pkg::reg_addr_t rd_id,
    output rv_pkg::word_t     imm_id,
    output rv_pkg::alu_op_e   alu_op_id,
    output logic              alu_src_id,
    output logic              reg_write_id,
    output logic              mem_read_id,
    output logic              mem_write_id,
    output logic              mem_to_reg_id
);
    import rv_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       bit30;

    assign opcode = instr_id[6:0];
    assign funct3 = instr_id[14:12];
    assign bit30  = instr_id[30];

    // Register operands go on to EX as read
    assign op_a_id = rs1_data;
    assign op_b_id = rs2_data;

    always_comb begin
        // Bubble unless a known opcode matches
        rs1_addr      = '0;
        rs2_addr      = '0;
        rd_id         = '0;
        imm_id        = {{20{instr_id[31]}}, instr_id[31:20]};
        alu_op_id     = ALU_ADD;
        alu_src_id    = 1'b0;
        reg_write_id  = 1'b0;
        mem_read_id   = 1'b0;
        mem_write_id  = 1'b0;
        mem_to_reg_id = 1'b0;
        case (opcode)
            OPC_OP, OPC_OP_IMM: begin
                rs1_addr     = instr_id[19:15];
                rd_id        = instr_id[11:7];
                reg_write_id = 1'b1;
                // rs2 field is immediate bits for OP_IMM
                rs2_addr     = (opcode == OPC_OP) ? instr_id[24:20] : '0;
                alu_src_id   = (opcode == OPC_OP_IMM);
                case (funct3)
                    3'b000: alu_op_id = (opcode == OPC_OP && bit30) ? ALU_SUB : ALU_ADD;
                    3'b001: alu_op_id = ALU_SLL;
                    3'b010: alu_op_id = ALU_SLT;
                    3'b011: alu_op_id = ALU_SLTU;
                    3'b100: alu_op_id = ALU_XOR;
                    // Bit 30 picks arithmetic shift in both forms
                    3'b101: alu_op_id = bit30 ? ALU_SRA : ALU_SRL;
                    3'b110: alu_op_id = ALU_OR;
                    default: alu_op_id = ALU_AND;
                endcase
            end
            OPC_LOAD: begin
                rs1_addr      = instr_id[19:15];
                rd_id         = instr_id[11:7];
                alu_src_id    = 1'b1;
                reg_write_id  = 1'b1;
                mem_read_id   = 1'b1;
                mem_to_reg_id = 1'b1;
            end
            OPC_STORE: begin
                rs1_addr     = instr_id[19:15];
                rs2_addr     = instr_id[24:20];
                // S-type offset split around rd field
                imm_id       = {{20{instr_id[31]}}, instr_id[31:25], instr_id[11:7]};
                alu_src_id   = 1'b1;
                mem_write_id = 1'b1;
            end
            default: ;
        endcase
    end

    // Load in EX feeding this instruction, one cycle of hold
    assign stall = mem_read_ex && (rd_ex != '0) &&
                   ((rd_ex == rs1_addr) || (rd_ex == rs2_addr));

endmodule

/* verilog/register_file.sv */
`timescale 1ns/1ns

module register_file (
    input  logic              clk,
    input  logic              rst_n,
    input  rv_pkg::reg_addr_t rs1_addr,
    input  rv_pkg::reg_addr_t rs2_addr,
    output rv_pkg::word_t     rs1_data,
    output rv_pkg::word_t     rs2_data,
    input  rv_pkg::reg_addr_t rd_wb,
    input  rv_pkg::word_t     wb_data,
    input  logic              reg_write_wb
);
    import rv_pkg::*;

    word_t regs [32];
    logic  wr_en;

    // x0 never takes a write
    assign wr_en = reg_write_wb && (rd_wb != '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[rd_wb] <= wb_data;
        end
    end

    // Bypass the write in flight to both read ports
    assign rs1_data = (wr_en && rd_wb == rs1_addr) ? wb_data : regs[rs1_addr];
    assign rs2_data = (wr_en && rd_wb == rs2_addr) ? wb_data : regs[rs2_addr];

endmodule

/* verilog/execute_stage.sv */
`timescale 1ns/1ns

module execute_stage (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              stall,
    input  rv_pkg::reg_addr_t rs1_addr,
    input  rv_pkg::reg_addr_t rs2_addr,
    input  rv_pkg::word_t     rs1_data,
    input  rv_pkg::word_t     rs2_data,
    input  rv_pkg::reg_addr_t rd_id,
    input  rv_pkg::word_t     imm_id,
    input  rv_pkg::alu_op_e   alu_op_id,
    input  logic              alu_src_id,
    input  logic              reg_write_id,
    input  logic              mem_read_id,
    input  logic              mem_write_id,
    input  logic              mem_to_reg_id,
    output rv_pkg::reg_addr_t rd_ex,
    output logic              mem_read_ex,
    input  rv_pkg::word_t     wb_data,
    input  rv_pkg::reg_addr_t rd_wb,
    input  logic              reg_write_wb,
    output rv_pkg::word_t     dmem_addr,
    output rv_pkg::word_t     dmem_wdata,
    output logic              dmem_we,
    output logic              dmem_re,
    output rv_pkg::word_t     alu_result_mem,
    output rv_pkg::reg_addr_t rd_mem,
    output logic              reg_write_mem,
    output logic              mem_to_reg_mem
);
    import rv_pkg::*;

    // ID/EX contents
    reg_addr_t rs1_ex;
    reg_addr_t rs2_ex;
    word_t     a_ex;
    word_t     b_ex;
    word_t     imm_ex;
    alu_op_e   alu_op_ex;
    logic      alu_src_ex;
    logic      reg_write_ex;
    logic      mem_write_ex;
    logic      mem_to_reg_ex;

    fwd_sel_e  fwd_a;
    fwd_sel_e  fwd_b;
    word_t     opa;
    word_t     store_data;
    word_t     opb;
    word_t     alu_result;

    // MEM result wins over WB and x0 is never forwarded
    function automatic fwd_sel_e pick_fwd(input reg_addr_t rs);
        if (reg_write_mem && rd_mem != '0 && rd_mem == rs) begin
            return FWD_MEM;
        end else if (reg_write_wb && rd_wb != '0 && rd_wb == rs) begin
            return FWD_WB;
        end
        return FWD_NONE;
    endfunction

    function automatic word_t fwd_mux(input fwd_sel_e sel, input word_t reg_val);
        case (sel)
            FWD_MEM: return alu_result_mem;
            FWD_WB:  return wb_data;
            default: return reg_val;
        endcase
    endfunction

    // ID/EX controls take a bubble on stall
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_ex         <= '0;
            reg_write_ex  <= 1'b0;
            mem_read_ex   <= 1'b0;
            mem_write_ex  <= 1'b0;
            mem_to_reg_ex <= 1'b0;
        end else if (stall) begin
            rd_ex         <= '0;
            reg_write_ex  <= 1'b0;
            mem_read_ex   <= 1'b0;
            mem_write_ex  <= 1'b0;
            mem_to_reg_ex <= 1'b0;
        end else begin
            rd_ex         <= rd_id;
            reg_write_ex  <= reg_write_id;
            mem_read_ex   <= mem_read_id;
            mem_write_ex  <= mem_write_id;
            mem_to_reg_ex <= mem_to_reg_id;
        end
    end

    // ID/EX operands
    always_ff @(posedge clk) begin
        rs1_ex     <= rs1_addr;
        rs2_ex     <= rs2_addr;
        a_ex       <= rs1_data;
        b_ex       <= rs2_data;
        imm_ex     <= imm_id;
        alu_op_ex  <= alu_op_id;
        alu_src_ex <= alu_src_id;
    end

    always_comb begin
        fwd_a      = pick_fwd(rs1_ex);
        fwd_b      = pick_fwd(rs2_ex);
        opa        = fwd_mux(fwd_a, a_ex);
        // Store data takes the same forwarded path as rs2
        store_data = fwd_mux(fwd_b, b_ex);
        opb        = alu_src_ex ? imm_ex : store_data;
    end

    always_comb begin
        case (alu_op_ex)
            ALU_SUB:  alu_result = opa - opb;
            ALU_AND:  alu_result = opa & opb;
            ALU_OR:   alu_result = opa | opb;
            ALU_XOR:  alu_result = opa ^ opb;
            ALU_SLT:  alu_result = {31'd0, $signed(opa) < $signed(opb)};
            ALU_SLTU: alu_result = {31'd0, opa < opb};
            // Shift amount is the low five bits only
            ALU_SLL:  alu_result = opa << opb[4:0];
            ALU_SRL:  alu_result = opa >> opb[4:0];
            ALU_SRA:  alu_result = word_t'($signed(opa) >>> opb[4:0]);
            default:  alu_result = opa + opb;
        endcase
    end

    // EX/MEM controls
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_mem         <= '0;
            reg_write_mem  <= 1'b0;
            mem_to_reg_mem <= 1'b0;
            dmem_we        <= 1'b0;
            dmem_re        <= 1'b0;
        end else begin
            rd_mem         <= rd_ex;
            reg_write_mem  <= reg_write_ex;
            mem_to_reg_mem <= mem_to_reg_ex;
            dmem_we        <= mem_write_ex;
            dmem_re        <= mem_read_ex;
        end
    end

    // EX/MEM data
    always_ff @(posedge clk) begin
        alu_result_mem <= alu_result;
        dmem_wdata     <= store_data;
    end

    // Effective address is the MEM-stage ALU result
    assign dmem_addr = alu_result_mem;

endmodule

/* verilog/writeback_stage.sv */
`timescale 1ns/1ns

module writeback_stage (
    input  logic              clk,
    input  logic              rst_n,
    input  rv_pkg::word_t     alu_result_mem,
    input  rv_pkg::word_t     dmem_rdata,
    input  rv_pkg::reg_addr_t rd_mem,
    input  logic              reg_write_mem,
    input  logic              mem_to_reg_mem,
    output rv_pkg::reg_addr_t rd_wb,
    output logic              reg_write_wb,
    output rv_pkg::word_t     wb_data
);
    import rv_pkg::*;

    word_t alu_result_wb;
    word_t load_data_wb;
    logic  mem_to_reg_wb;

    // MEM/WB controls
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_wb         <= '0;
            reg_write_wb  <= 1'b0;
            mem_to_reg_wb <= 1'b0;
        end else begin
            rd_wb         <= rd_mem;
            reg_write_wb  <= reg_write_mem;
            mem_to_reg_wb <= mem_to_reg_mem;
        end
    end

    // Read data arrives the same cycle as the strobe
    always_ff @(posedge clk) begin
        alu_result_wb <= alu_result_mem;
        load_data_wb  <= dmem_rdata;
    end

    assign wb_data = mem_to_reg_wb ? load_data_wb : alu_result_wb;

endmodule

/* verilog/cpu_top.sv */
`timescale 1ns/1ns

module cpu_top #(
    parameter rv_pkg::word_t RESET_PC = 32'h0000_0000
) (
    input  logic          clk,
    input  logic          rst_n,
    output rv_pkg::word_t imem_addr,
    input  rv_pkg::word_t imem_data,
    output rv_pkg::word_t dmem_addr,
    output rv_pkg::word_t dmem_wdata,
    input  rv_pkg::word_t dmem_rdata,
    output logic          dmem_we,
    output logic          dmem_re
);
    import rv_pkg::*;

    // IF/ID
    word_t     instr_id;
    logic      stall;

    // Decode outputs
    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    word_t     rs1_data;
    word_t     rs2_data;
    word_t     op_a_id;
    word_t     op_b_id;
    reg_addr_t rd_id;
    word_t     imm_id;
    alu_op_e   alu_op_id;
    logic      alu_src_id;
    logic      reg_write_id;
    logic      mem_read_id;
    logic      mem_write_id;
    logic      mem_to_reg_id;

    // EX back to hazard check
    reg_addr_t rd_ex;
    logic      mem_read_ex;

    // MEM stage
    word_t     alu_result_mem;
    reg_addr_t rd_mem;
    logic      reg_write_mem;
    logic      mem_to_reg_mem;

    // WB stage, also the forwarding source
    word_t     wb_data;
    reg_addr_t rd_wb;
    logic      reg_write_wb;

    fetch_stage #(
        .RESET_PC (RESET_PC)
    ) u_fetch (
        .clk       (clk),
        .rst_n     (rst_n),
        .stall     (stall),
        .imem_addr (imem_addr),
        .imem_data (imem_data),
        .instr_id  (instr_id)
    );

    decode_stage u_decode (
        .instr_id      (instr_id),
        .rs1_addr      (rs1_addr),
        .rs2_addr      (rs2_addr),
        .rs1_data      (rs1_data),
        .rs2_data      (rs2_data),
        .op_a_id       (op_a_id),
        .op_b_id       (op_b_id),
        .rd_ex         (rd_ex),
        .mem_read_ex   (mem_read_ex),
        .stall         (stall),
        .rd_id         (rd_id),
        .imm_id        (imm_id),
        .alu_op_id     (alu_op_id),
        .alu_src_id    (alu_src_id),
        .reg_write_id  (reg_write_id),
        .mem_read_id   (mem_read_id),
        .mem_write_id  (mem_write_id),
        .mem_to_reg_id (mem_to_reg_id)
    );

    register_file u_regs (
        .clk          (clk),
        .rst_n        (rst_n),
        .rs1_addr     (rs1_addr),
        .rs2_addr     (rs2_addr),
        .rs1_data     (rs1_data),
        .rs2_data     (rs2_data),
        .rd_wb        (rd_wb),
        .wb_data      (wb_data),
        .reg_write_wb (reg_write_wb)
    );

    execute_stage u_execute (
        .clk            (clk),
        .rst_n          (rst_n),
        .stall          (stall),
        .rs1_addr       (rs1_addr),
        .rs2_addr       (rs2_addr),
        .rs1_data       (op_a_id),
        .rs2_data       (op_b_id),
        .rd_id          (rd_id),
        .imm_id         (imm_id),
        .alu_op_id      (alu_op_id),
        .alu_src_id     (alu_src_id),
        .reg_write_id   (reg_write_id),
        .mem_read_id    (mem_read_id),
        .mem_write_id   (mem_write_id),
        .mem_to_reg_id  (mem_to_reg_id),
        .rd_ex          (rd_ex),
        .mem_read_ex    (mem_read_ex),
        .wb_data        (wb_data),
        .rd_wb          (rd_wb),
        .reg_write_wb   (reg_write_wb),
        .dmem_addr      (dmem_addr),
        .dmem_wdata     (dmem_wdata),
        .dmem_we        (dmem_we),
        .dmem_re        (dmem_re),
        .alu_result_mem (alu_result_mem),
        .rd_mem         (rd_mem),
        .reg_write_mem  (reg_write_mem),
        .mem_to_reg_mem (mem_to_reg_mem)
    );

    writeback_stage u_writeback (
        .clk            (clk),
        .rst_n          (rst_n),
        .alu_result_mem (alu_result_mem),
        .dmem_rdata     (dmem_rdata),
        .rd_mem         (rd_mem),
        .reg_write_mem  (reg_write_mem),
        .mem_to_reg_mem (mem_to_reg_mem),
        .rd_wb          (rd_wb),
        .reg_write_wb   (reg_write_wb),
        .wb_data        (wb_data)
    );

endmodule

/* sim/cpu_properties.sv */
`timescale 1ns/1ns

module cpu_properties #(
    parameter rv_pkg::word_t RESET_PC = 32'h0000_0000
) (
    input logic          clk,
    input logic          rst_n,
    input rv_pkg::word_t imem_addr,
    input logic          dmem_we,
    input logic          dmem_re
);

    // Failed assertions, read back by the testbench at the end
    int unsigned fail_count = 0;

    // Read and write strobes are exclusive
    a_strobes_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(dmem_we && dmem_re))
        else begin
            fail_count++;
            $error("dmem_we and dmem_re high in the same cycle");
        end

    a_fetch_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        imem_addr[1:0] == 2'b00)
        else begin
            fail_count++;
            $error("imem_addr not word aligned");
        end

    // No branches, so the PC only steps or holds
    a_fetch_step: assert property (@(posedge clk) disable iff (!rst_n)
        $past(rst_n) |-> (imem_addr == $past(imem_addr) ||
                          imem_addr == $past(imem_addr) + 32'd4))
        else begin
            fail_count++;
            $error("imem_addr neither held nor advanced by four");
        end

    // A load-use stall lasts one cycle, never two in a row
    a_single_hold: assert property (@(posedge clk) disable iff (!rst_n)
        ($past(rst_n, 2) && imem_addr == $past(imem_addr)) |->
            imem_addr != $past(imem_addr, 2))
        else begin
            fail_count++;
            $error("imem_addr held for two consecutive cycles");
        end

    // First cycle out of reset
    a_reset_exit: assert property (@(posedge clk)
        $rose(rst_n) |-> (!dmem_we && !dmem_re && imem_addr == RESET_PC))
        else begin
            fail_count++;
            $error("bad strobes or fetch address right after reset");
        end

endmodule

/* sim/cpu_tb.sv */
`timescale 1ns/1ns

module cpu_tb;
    import rv_pkg::*;

    // Nonzero fetch start address
    localparam word_t RESET_PC     = 32'h0000_0100;
    localparam int    RESET_CYCLES = 5;
    // About 60 instructions, two stalls and pipeline fill, with wide margin
    localparam int    CYCLE_LIMIT  = 200;
    localparam int    DRAIN_CYCLES = 8;

    // RV32I major opcodes for program building
    localparam logic [6:0] ENC_OP     = 7'b0110011;
    localparam logic [6:0] ENC_OP_IMM = 7'b0010011;
    localparam logic [6:0] ENC_LOAD   = 7'b0000011;
    localparam logic [6:0] ENC_STORE  = 7'b0100011;
    localparam word_t      NOP        = 32'h0000_0013;

    logic  clk = 1'b0;
    logic  rst_n;
    word_t imem_addr;
    word_t imem_data;
    word_t dmem_addr;
    word_t dmem_wdata;
    word_t dmem_rdata;
    logic  dmem_we;
    logic  dmem_re;

    // Memories and the architectural model
    word_t imem [128];
    word_t dmem [256];
    word_t model_regs [32];
    word_t imem_off;
    int    prog_len;
    int    store_off;
    word_t lcg_state = 32'hd0b9;

    // Expected stores in program order
    word_t exp_addr_q [$];
    word_t exp_data_q [$];
    word_t exp_addr;
    word_t exp_data;
    int    exp_total;

    int cycles = 0;
    int stores_seen = 0;
    int store_errors = 0;
    int missing_errors = 0;
    int extra_errors = 0;
    int prop_errors = 0;

    // R-type order is ADD SUB AND OR XOR SLT SLTU SLL SRL SRA
    logic [2:0] op_f3 [10] = '{3'b000, 3'b000, 3'b111, 3'b110, 3'b100,
                               3'b010, 3'b011, 3'b001, 3'b101, 3'b101};
    logic       op_alt [10] = '{1'b0, 1'b1, 1'b0, 1'b0, 1'b0,
                                1'b0, 1'b0, 1'b0, 1'b0, 1'b1};
    // I-type order is ADDI SLTI SLTIU XORI ORI ANDI SLLI SRLI SRAI
    logic [2:0] imm_f3 [9] = '{3'b000, 3'b010, 3'b011, 3'b100, 3'b110,
                               3'b111, 3'b001, 3'b101, 3'b101};

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
    end

    cpu_top #(
        .RESET_PC (RESET_PC)
    ) i_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .imem_addr  (imem_addr),
        .imem_data  (imem_data),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_rdata (dmem_rdata),
        .dmem_we    (dmem_we),
        .dmem_re    (dmem_re)
    );

    bind cpu_top cpu_properties #(
        .RESET_PC (RESET_PC)
    ) u_props (
        .clk       (clk),
        .rst_n     (rst_n),
        .imem_addr (imem_addr),
        .dmem_we   (dmem_we),
        .dmem_re   (dmem_re)
    );

    // Instruction memory answers NOP past the program window
    assign imem_off   = imem_addr - RESET_PC;
    assign imem_data  = (imem_off < 32'd512) ? imem[imem_off[8:2]] : NOP;
    // Data memory answers in the same cycle
    // Store targets lie above the loaded words
    assign dmem_rdata = dmem_re ? dmem[dmem_addr[9:2]] : 32'd0;

    function automatic word_t lcg_next(input word_t x);
        return x * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [11:0] next_imm();
        lcg_state = lcg_next(lcg_state);
        return lcg_state[27:16];
    endfunction

    function automatic word_t sext12(input logic [11:0] imm);
        return {{20{imm[11]}}, imm};
    endfunction

    // Integer result per RV32I funct3 with alt as instruction bit 30
    function automatic word_t isa_alu(input logic [2:0] f3, input logic alt,
                                      input word_t a, input word_t b);
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011:  return (a < b) ? 32'd1 : 32'd0;
            3'b100:  return a ^ b;
            3'b101:  return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic put_instr(input word_t instr);
        imem[prog_len] = instr;
        prog_len++;
    endtask

    // x0 stays zero in the model too
    task automatic set_reg(input reg_addr_t rd, input word_t val);
        if (rd != 5'd0) begin
            model_regs[rd] = val;
        end
    endtask

    task automatic emit_op(input logic [2:0] f3, input logic alt, input reg_addr_t rd,
                           input reg_addr_t rs1, input reg_addr_t rs2);
        put_instr({alt ? 7'b0100000 : 7'b0000000, rs2, rs1, f3, rd, ENC_OP});
        set_reg(rd, isa_alu(f3, alt, model_regs[rs1], model_regs[rs2]));
    endtask

    task automatic emit_opi(input logic [2:0] f3, input reg_addr_t rd,
                            input reg_addr_t rs1, input logic [11:0] imm);
        logic alt;
        // Only SRAI uses bit 30 in the immediate forms
        alt = (f3 == 3'b101) && imm[10];
        put_instr({imm, rs1, f3, rd, ENC_OP_IMM});
        set_reg(rd, isa_alu(f3, alt, model_regs[rs1], sext12(imm)));
    endtask

    task automatic emit_lw(input reg_addr_t rd, input reg_addr_t rs1, input logic [11:0] imm);
        word_t addr;
        addr = model_regs[rs1] + sext12(imm);
        put_instr({imm, rs1, 3'b010, rd, ENC_LOAD});
        set_reg(rd, dmem[addr[9:2]]);
    endtask

    task automatic emit_sw(input reg_addr_t rs2, input reg_addr_t rs1, input logic [11:0] imm);
        put_instr({imm[11:5], rs2, rs1, 3'b010, imm[4:0], ENC_STORE});
        exp_addr_q.push_back(model_regs[rs1] + sext12(imm));
        exp_data_q.push_back(model_regs[rs2]);
    endtask

    // Each result gets its own word off the x10 base
    task automatic store_result(input reg_addr_t rs2);
        emit_sw(rs2, 5'd10, store_off[11:0]);
        store_off = store_off + 4;
    endtask

    task automatic build_program();
        logic [11:0] imm;
        prog_len  = 0;
        store_off = -64;
        emit_opi(3'b000, 5'd10, 5'd0, 12'h300);
        emit_lw(5'd1, 5'd0, 12'h000);
        emit_lw(5'd2, 5'd0, 12'h004);
        // Load then immediate use costs one stall
        emit_lw(5'd3, 5'd0, 12'h008);
        emit_opi(3'b000, 5'd4, 5'd3, next_imm());
        store_result(5'd4);
        // Every R-type op with store data forwarded from MEM
        for (int k = 0; k < 10; k++) begin
            emit_op(op_f3[k], op_alt[k], 5'd5, 5'd1, 5'd2);
            store_result(5'd5);
        end
        for (int k = 0; k < 9; k++) begin
            imm = next_imm();
            if (k == 6 || k == 7) begin
                imm = {7'b0000000, imm[4:0]};
            end else if (k == 8) begin
                imm = {7'b0100000, imm[4:0]};
            end
            emit_opi(imm_f3[k], 5'd6, 5'd1, imm);
            store_result(5'd6);
        end
        // x7 at distance two and x8 at distance one
        emit_op(3'b000, 1'b0, 5'd7, 5'd1, 5'd2);
        emit_op(3'b100, 1'b0, 5'd8, 5'd2, 5'd1);
        emit_op(3'b000, 1'b1, 5'd9, 5'd7, 5'd8);
        store_result(5'd9);
        // Newer x11 in MEM must beat older x11 in WB
        emit_opi(3'b000, 5'd11, 5'd1, 12'h005);
        emit_opi(3'b000, 5'd11, 5'd11, 12'h007);
        emit_opi(3'b000, 5'd12, 5'd11, 12'h001);
        store_result(5'd12);
        store_result(5'd7);
        // Load feeding store data stalls and then forwards from WB
        emit_lw(5'd13, 5'd0, 12'h00c);
        store_result(5'd13);
        // Write to x0 is dropped and not forwarded either
        emit_opi(3'b000, 5'd0, 5'd1, 12'h07b);
        store_result(5'd0);
        emit_op(3'b000, 1'b0, 5'd14, 5'd0, 5'd1);
        store_result(5'd14);
        // Late read of x0 comes from the register array
        store_result(5'd0);
    endtask

    // Store monitor samples mid-cycle where the port is settled
    always @(negedge clk) begin
        if (rst_n && dmem_we) begin
            if (exp_addr_q.size() == 0) begin
                extra_errors++;
                $display("Unexpected extra store to address %h at %0t ns", dmem_addr, $time);
            end else begin
                exp_addr = exp_addr_q.pop_front();
                exp_data = exp_data_q.pop_front();
                stores_seen++;
                check_store: assert (dmem_addr == exp_addr && dmem_wdata == exp_data)
                else begin
                    store_errors++;
                    $display("ERROR %0t ns: store addr %h data %h, expected addr %h data %h",
                             $time, dmem_addr, dmem_wdata, exp_addr, exp_data);
                end
            end
        end
    end

    initial begin
        rst_n = 1'b0;
        // Data words straight from the LCG stream
        for (int i = 0; i < 256; i++) begin
            lcg_state = lcg_next(lcg_state);
            dmem[i]   = lcg_state;
        end
        for (int i = 0; i < 128; i++) begin
            imem[i] = NOP;
        end
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = 32'd0;
        end
        build_program();
        exp_total = exp_addr_q.size();

        repeat (RESET_CYCLES) @(posedge clk);
        #1 rst_n = 1'b1;

        // Run until the last expected store or the cycle limit
        while (stores_seen < exp_total && cycles < CYCLE_LIMIT) begin
            @(posedge clk);
        end
        // Catch stray stores after the program
        repeat (DRAIN_CYCLES) @(posedge clk);

        if (stores_seen < exp_total) begin
            missing_errors = exp_total - stores_seen;
            $display("Timeout after %0d cycles, only %0d of %0d stores were seen",
                     cycles, stores_seen, exp_total);
        end
        prop_errors = i_dut.u_props.fail_count;

        $display("Errors: %0d store mismatches, %0d missing, %0d extra, %0d property failures",
                 store_errors, missing_errors, extra_errors, prop_errors);
        if (store_errors + missing_errors + extra_errors + prop_errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

/* all.f */
verilog/rv_pkg.sv
verilog/fetch_stage.sv
verilog/decode_stage.sv
verilog/register_file.sv
verilog/execute_stage.sv
verilog/writeback_stage.sv
verilog/cpu_top.sv
sim/cpu_properties.sv
sim/cpu_tb.sv

/* Makefile */
VERILATOR  ?= verilator
FILELIST   ?= all.f
TOP        ?= cpu_tb
RTL_TOP    ?= cpu_top
BUILD_DIR  ?= obj_dir
SIM_FLAGS  ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only -Wall
RTL_FILES  ?= verilog/rv_pkg.sv verilog/fetch_stage.sv verilog/decode_stage.sv \
              verilog/register_file.sv verilog/execute_stage.sv \
              verilog/writeback_stage.sv verilog/cpu_top.sv
PASS_MSG   ?= Simulation PASSED

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_FILES)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -o $(TOP) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
